// ==== tag_tracker_top.f ====
tag_pkg.sv
bsg_id_pool.sv
tag_table.sv
req_issue.sv
resp_return.sv
tag_tracker_top.sv
tb_tag_tracker.sv

// ==== tb_tag_tracker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the tag tracker. random
// traffic against an out-of-order memory
// model and a tag-predicting reference.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_tag_tracker;

  import tag_pkg::*;

  logic       clk;
  logic       reset_n;
  logic       up_req_v, up_req_ready, down_req_v, down_req_yumi;
  logic       down_resp_v, down_resp_ready, up_resp_v, up_resp_yumi;
  up_req_s    up_req;
  down_req_s  down_req, exp_down, prev_down;
  down_resp_s down_resp;
  up_resp_s   up_resp, prev_up, last_resp;

  // memory behind the port and the reference view of it
  logic [data_width_lp-1:0] mem [0:65535];
  logic [data_width_lp-1:0] shadow [0:65535];
  down_resp_s               pend_q[$];
  int                       pend_delay[$];
  up_req_s                  stim_q[$];
  up_resp_s                 exp_q [num_tags_lp][$];
  up_resp_s                 ret_q[$];
  logic [tag_width_lp-1:0]  issued_tags[$];
  logic [num_tags_lp-1:0]   busy;

  int seed, errors, checks, tests_run, test_err;
  int n_acc, n_issued, n_returned, n_done;
  int yumi_pct, resp_pct, force_tag;
  bit resp_en, aborted, full_expected, load_down, load_up, hold_down, hold_up;

  tag_tracker_top DUT (
    .clk_i             (clk),
    .reset_i           (reset_n),
    .up_req_v_i        (up_req_v),
    .up_req_i          (up_req),
    .up_req_ready_o    (up_req_ready),
    .down_req_v_o      (down_req_v),
    .down_req_o        (down_req),
    .down_req_yumi_i   (down_req_yumi),
    .down_resp_v_i     (down_resp_v),
    .down_resp_i       (down_resp),
    .down_resp_ready_o (down_resp_ready),
    .up_resp_v_o       (up_resp_v),
    .up_resp_o         (up_resp),
    .up_resp_yumi_i    (up_resp_yumi)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: got %h expected %h", name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  function automatic int rnd(input int range);
    rnd = ($random(seed) & 32'h7fff_ffff) % range;
  endfunction

  // reads spread over the whole address space
  // mixed traffic stays in a small window so reads hit earlier writes
  task automatic queue_reqs(input int count, input bit mixed);
    up_req_s r;
    for (int i = 0; i < count; i++) begin
      r.src   = mixed ? src_width_lp'(rnd(16)) : src_width_lp'(i);
      r.op    = mixed ? mem_op_e'(rnd(2)) : mem_read;
      r.addr  = addr_width_lp'(mixed ? rnd(32) : rnd(65536));
      r.wdata = data_width_lp'($random(seed));
      stim_q.push_back(r);
    end
  endtask

  // one clock that checks at the falling edge and drives after the rising edge
  task automatic step();
    logic [tag_width_lp-1:0] tag;
    up_resp_s                exp;
    int                      idx;
    bit                      exp_down_v;
    bit                      exp_up_v;
    @(negedge clk);
    // loaded or held registers are expected valid
    exp_down_v = load_down || hold_down;
    exp_up_v   = load_up || hold_up;
    check_value("down_req_v_o", down_req_v, exp_down_v);
    check_value("up_resp_v_o", up_resp_v, exp_up_v);
    if (load_down) check_value("down_req_o", down_req, exp_down);
    if (hold_down) check_value("down_req_o", down_req, prev_down);
    if (hold_up) check_value("up_resp_o", up_resp, prev_up);
    if (full_expected) check_value("up_req_ready_o", up_req_ready, 1'b0);
    // a held upstream response blocks the downstream side
    check_value("down_resp_ready_o", down_resp_ready, !exp_up_v || up_resp_yumi);
    // response side first since a freed tag is offered again in the same cycle
    load_up = down_resp_v && down_resp_ready;
    if (load_up) begin
      tag = down_resp.tag;
      busy[tag] = 1'b0;
      n_returned++;
      if (exp_q[tag].size() == 0) report_failure("response came back for a tag not in use");
      else ret_q.push_back(exp_q[tag].pop_front());
    end
    if (up_resp_v && up_resp_yumi) begin
      n_done++;
      last_resp = up_resp;
      if (ret_q.size() == 0) report_failure("upstream response appeared with none expected");
      else check_value("up_resp_o", up_resp, ret_q.pop_front());
    end
    load_down = up_req_v && up_req_ready;
    if (load_down) begin
      idx = 0;
      while (idx < num_tags_lp - 1 && busy[idx]) idx++;
      if (busy[idx]) report_failure("request accepted while every tag was in use");
      tag = tag_width_lp'(idx);
      busy[tag] = 1'b1;
      exp.src   = up_req.src;
      exp.op    = up_req.op;
      exp.rdata = (up_req.op == mem_read) ? shadow[up_req.addr] : '0;
      if (up_req.op == mem_write) shadow[up_req.addr] = up_req.wdata;
      exp_q[tag].push_back(exp);
      exp_down = {tag, up_req.op, up_req.addr, up_req.wdata};
      n_acc++;
    end
    // memory acts when it takes the request and answers later
    if (down_req_v && down_req_yumi) begin
      n_issued++;
      issued_tags.push_back(down_req.tag);
      if (down_req.op == mem_write) mem[down_req.addr] = down_req.wdata;
      pend_q.push_back({down_req.tag, (down_req.op == mem_read) ?
                        mem[down_req.addr] : data_width_lp'($random(seed))});
      pend_delay.push_back(rnd(6));
    end
    hold_down = exp_down_v && !down_req_yumi;
    hold_up   = exp_up_v && !up_resp_yumi;
    prev_down = down_req;
    prev_up   = up_resp;
    @(posedge clk);
    #1;
    if (load_down) stim_q.delete(0);
    up_req_v = (stim_q.size() != 0);
    if (up_req_v) up_req = stim_q[0];
    if (load_up) down_resp_v = 1'b0;
    foreach (pend_delay[i]) begin
      if (pend_delay[i] > 0) pend_delay[i]--;
    end
    if (resp_en && !down_resp_v && pend_q.size() != 0) begin
      idx = -1;
      if (force_tag >= 0) begin
        foreach (pend_q[i]) begin
          if (pend_q[i].tag == force_tag) idx = i;
        end
      end else if (rnd(100) < resp_pct) begin
        idx = rnd(pend_q.size());
        if (pend_delay[idx] != 0) idx = -1;
      end
      if (idx >= 0) begin
        down_resp_v = 1'b1;
        down_resp   = pend_q[idx];
        pend_q.delete(idx);
        pend_delay.delete(idx);
      end
    end
    down_req_yumi = down_req_v && (rnd(100) < yumi_pct);
    up_resp_yumi  = up_resp_v && (rnd(100) < yumi_pct);
  endtask

  // 0 waits on the issued count and 1 on the returned count
  // anything else waits for all traffic to drain
  function automatic bit reached(input int which, input int target);
    case (which)
      0:       reached = (n_issued >= target);
      1:       reached = (n_returned >= target);
      default: reached = (stim_q.size() == 0) && !up_req_v && (n_done == n_acc) && !up_resp_v;
    endcase
  endfunction

  task automatic wait_for(input int which, input int target, input string what);
    int n;
    n = 0;
    while (!aborted && !reached(which, target)) begin
      step();
      n++;
      if (n > 20000) begin
        report_failure($sformatf("timeout after %0d cycles waiting for %s", n, what));
        aborted = 1'b1;
      end
    end
  endtask

  task automatic start_test();
    test_err = errors;
    issued_tags.delete();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %s: %0d errors", name, errors - test_err);
  endtask

  initial begin
    clk           = 1'b0;
    reset_n       = 1'b0;
    up_req_v      = 1'b0;
    up_req        = '0;
    down_req_yumi = 1'b0;
    down_resp_v   = 1'b0;
    down_resp     = '0;
    up_resp_yumi  = 1'b0;
    seed      = 75;
    busy      = '0;
    force_tag = -1;
    resp_en   = 1'b1;
    yumi_pct  = 100;
    resp_pct  = 100;
    for (int a = 0; a < 65536; a++) begin
      mem[a]    = {~16'(a), 16'(a)};
      shadow[a] = {~16'(a), 16'(a)};
    end
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    @(negedge clk);
    start_test();
    check_value("down_req_v_o", down_req_v, 1'b0);
    check_value("up_resp_v_o", up_resp_v, 1'b0);
    check_value("up_req_ready_o", up_req_ready, 1'b1);
    check_value("down_resp_ready_o", down_resp_ready, 1'b1);
    end_test("reset");

    if (!aborted) begin
      start_test();
      stim_q.push_back({4'h3, mem_write, 16'h0040, 32'hcafe_0123});
      wait_for(2, 0, "write round trip");
      check_value("down_req_o.tag", issued_tags[0], 0);
      check_value("up_resp_o", last_resp, {4'h3, mem_write, 32'h0});
      stim_q.push_back({4'h4, mem_read, 16'h0040, 32'h0});
      wait_for(2, 0, "read round trip");
      check_value("down_req_o.tag", issued_tags[1], 0);
      check_value("up_resp_o", last_resp, {4'h4, mem_read, 32'hcafe_0123});
      end_test("round_trip");
    end

    if (!aborted) begin
      start_test();
      resp_en = 1'b0;
      queue_reqs(8, 1'b0);
      wait_for(0, n_issued + 8, "eight tags to issue");
      for (int i = 0; i < 8; i++) check_value("down_req_o.tag", issued_tags[i], i);
      full_expected = 1'b1;
      repeat (4) step();
      full_expected = 1'b0;
      force_tag = 5;
      resp_en   = 1'b1;
      wait_for(1, n_returned + 1, "tag 5 to return");
      resp_en   = 1'b0;
      force_tag = -1;
      queue_reqs(1, 1'b0);
      wait_for(0, n_issued + 1, "reissue of a freed tag");
      check_value("down_req_o.tag", issued_tags[8], 5);
      resp_en = 1'b1;
      wait_for(2, 0, "exhaustion drain");
      end_test("exhaustion");
    end

    if (!aborted) begin
      start_test();
      resp_en = 1'b0;
      queue_reqs(8, 1'b0);
      wait_for(0, n_issued + 8, "eight reads to issue");
      resp_en = 1'b1;
      wait_for(2, 0, "out of order return");
      end_test("out_of_order");
    end

    if (!aborted) begin
      start_test();
      yumi_pct = 25;
      resp_pct = 40;
      queue_reqs(40, 1'b1);
      wait_for(2, 0, "back-pressure traffic");
      check_value("issued count", n_issued, n_acc);
      check_value("returned count", n_returned, n_acc);
      end_test("back_pressure");
    end

    if (!aborted) begin
      start_test();
      yumi_pct = 70;
      resp_pct = 60;
      queue_reqs(300, 1'b1);
      wait_for(2, 0, "random stress");
      resp_en  = 1'b0;
      yumi_pct = 100;
      issued_tags.delete();
      queue_reqs(8, 1'b0);
      wait_for(0, n_issued + 8, "final tag sweep");
      for (int i = 0; i < 8; i++) check_value("down_req_o.tag", issued_tags[i], i);
      resp_en = 1'b1;
      wait_for(2, 0, "final drain");
      end_test("stress");
    end

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tag_tracker_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request tag tracker top level. ties the
// issue and return paths to the tag pool
// and the per-tag context table.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tag_tracker_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // upstream request, valid/ready
  input  logic                  up_req_v_i,
  input  tag_pkg::up_req_s      up_req_i,
  output logic                  up_req_ready_o,
  // downstream request, valid/yumi
  output logic                  down_req_v_o,
  output tag_pkg::down_req_s    down_req_o,
  input  logic                  down_req_yumi_i,
  // downstream response, valid/ready
  input  logic                  down_resp_v_i,
  input  tag_pkg::down_resp_s   down_resp_i,
  output logic                  down_resp_ready_o,
  // upstream response, valid/yumi
  output logic                  up_resp_v_o,
  output tag_pkg::up_resp_s     up_resp_o,
  input  logic                  up_resp_yumi_i
);

  import tag_pkg::*;

  // pool handshake
  logic                    alloc_v;
  logic [tag_width_lp-1:0] alloc_id;
  logic                    alloc_yumi;
  logic                    dealloc_v;
  logic [tag_width_lp-1:0] dealloc_id;

  // table ports
  logic                    tbl_wr_v;
  logic [tag_width_lp-1:0] tbl_wr_tag;
  tag_entry_s              tbl_wr_entry;
  logic [tag_width_lp-1:0] tbl_rd_tag;
  tag_entry_s              tbl_rd_entry;

  req_issue issue (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .up_req_v_i      (up_req_v_i),
    .up_req_i        (up_req_i),
    .up_req_ready_o  (up_req_ready_o),
    .alloc_v_i       (alloc_v),
    .alloc_id_i      (alloc_id),
    .alloc_yumi_o    (alloc_yumi),
    .tbl_wr_v_o      (tbl_wr_v),
    .tbl_wr_tag_o    (tbl_wr_tag),
    .tbl_wr_entry_o  (tbl_wr_entry),
    .down_req_v_o    (down_req_v_o),
    .down_req_o      (down_req_o),
    .down_req_yumi_i (down_req_yumi_i)
  );

  resp_return ret (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .down_resp_v_i     (down_resp_v_i),
    .down_resp_i       (down_resp_i),
    .down_resp_ready_o (down_resp_ready_o),
    .tbl_rd_tag_o      (tbl_rd_tag),
    .tbl_rd_entry_i    (tbl_rd_entry),
    .dealloc_v_o       (dealloc_v),
    .dealloc_id_o      (dealloc_id),
    .up_resp_v_o       (up_resp_v_o),
    .up_resp_o         (up_resp_o),
    .up_resp_yumi_i    (up_resp_yumi_i)
  );

  bsg_id_pool pool (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .alloc_id_o   (alloc_id),
    .alloc_v_o    (alloc_v),
    .alloc_yumi_i (alloc_yumi),
    .dealloc_v_i  (dealloc_v),
    .dealloc_id_i (dealloc_id)
  );

  tag_table table_inst (
    .clk_i      (clk_i),
    .wr_v_i     (tbl_wr_v),
    .wr_tag_i   (tbl_wr_tag),
    .wr_entry_i (tbl_wr_entry),
    .rd_tag_i   (tbl_rd_tag),
    .rd_entry_o (tbl_rd_entry)
  );

endmodule

// ==== resp_return.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// response path. looks up the context of
// each returning tag, frees the tag and
// registers the upstream response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module resp_return (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // downstream responses, valid/ready
  input  logic                             down_resp_v_i,
  input  tag_pkg::down_resp_s              down_resp_i,
  output logic                             down_resp_ready_o,
  // table read port
  output logic [tag_pkg::tag_width_lp-1:0] tbl_rd_tag_o,
  input  tag_pkg::tag_entry_s              tbl_rd_entry_i,
  // tag release to the pool
  output logic                             dealloc_v_o,
  output logic [tag_pkg::tag_width_lp-1:0] dealloc_id_o,
  // upstream responses, valid/yumi
  output logic                             up_resp_v_o,
  output tag_pkg::up_resp_s                up_resp_o,
  input  logic                             up_resp_yumi_i
);

  import tag_pkg::*;

  logic     up_resp_v_r;
  up_resp_s up_resp_r;
  up_resp_s up_resp_next;
  logic     accept;

  assign down_resp_ready_o = ~up_resp_v_r | up_resp_yumi_i;
  assign accept            = down_resp_v_i & down_resp_ready_o;

  assign tbl_rd_tag_o = down_resp_i.tag;

  // tag goes back at the accepting edge
  assign dealloc_v_o  = accept;
  assign dealloc_id_o = down_resp_i.tag;

  // writes report zero data
  always_comb begin
    up_resp_next.src   = tbl_rd_entry_i.src;
    up_resp_next.op    = tbl_rd_entry_i.op;
    up_resp_next.rdata = (tbl_rd_entry_i.op == mem_read) ? down_resp_i.rdata : '0;
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      up_resp_v_r <= 1'b0;
    end else if (accept) begin
      up_resp_v_r <= 1'b1;
    end else if (up_resp_yumi_i) begin
      up_resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      up_resp_r <= up_resp_next;
    end
  end

  assign up_resp_v_o = up_resp_v_r;
  assign up_resp_o   = up_resp_r;

endmodule

// ==== req_issue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request path. claims a tag per accepted
// upstream request, records its context and
// registers the tagged downstream request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module req_issue (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // upstream requests, valid/ready
  input  logic                             up_req_v_i,
  input  tag_pkg::up_req_s                 up_req_i,
  output logic                             up_req_ready_o,
  // tag pool
  input  logic                             alloc_v_i,
  input  logic [tag_pkg::tag_width_lp-1:0] alloc_id_i,
  output logic                             alloc_yumi_o,
  // table write port
  output logic                             tbl_wr_v_o,
  output logic [tag_pkg::tag_width_lp-1:0] tbl_wr_tag_o,
  output tag_pkg::tag_entry_s              tbl_wr_entry_o,
  // downstream requests, valid/yumi
  output logic                             down_req_v_o,
  output tag_pkg::down_req_s               down_req_o,
  input  logic                             down_req_yumi_i
);

  import tag_pkg::*;

  logic      down_req_v_r;
  down_req_s down_req_r;
  down_req_s down_req_next;
  logic      accept;

  // output slot frees up when empty or being taken now
  assign up_req_ready_o = alloc_v_i & (~down_req_v_r | down_req_yumi_i);
  assign accept         = up_req_v_i & up_req_ready_o;

  assign alloc_yumi_o = accept;

  // context saved for the return path
  assign tbl_wr_v_o          = accept;
  assign tbl_wr_tag_o        = alloc_id_i;
  assign tbl_wr_entry_o.src  = up_req_i.src;
  assign tbl_wr_entry_o.op   = up_req_i.op;
  assign tbl_wr_entry_o.addr = up_req_i.addr;

  always_comb begin
    down_req_next.tag   = alloc_id_i;
    down_req_next.op    = up_req_i.op;
    down_req_next.addr  = up_req_i.addr;
    down_req_next.wdata = up_req_i.wdata;
  end

  // valid bit: load wins over yumi
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      down_req_v_r <= 1'b0;
    end else if (accept) begin
      down_req_v_r <= 1'b1;
    end else if (down_req_yumi_i) begin
      down_req_v_r <= 1'b0;
    end
  end

  // payload held until the next accept
  always_ff @(posedge clk_i) begin
    if (accept) begin
      down_req_r <= down_req_next;
    end
  end

  assign down_req_v_o = down_req_v_r;
  assign down_req_o   = down_req_r;

endmodule

// ==== tag_table.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-tag context store. one synchronous
// write port from the issue side, one
// combinational read port for responses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tag_table (
  input  logic                             clk_i,
  // write side, filled when a tag is claimed
  input  logic                             wr_v_i,
  input  logic [tag_pkg::tag_width_lp-1:0] wr_tag_i,
  input  tag_pkg::tag_entry_s              wr_entry_i,
  // read side, looked up by response tag
  input  logic [tag_pkg::tag_width_lp-1:0] rd_tag_i,
  output tag_pkg::tag_entry_s              rd_entry_o
);

  import tag_pkg::*;

  // entries are always written before a tag can come back
  tag_entry_s entries_r [num_tags_lp];

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      entries_r[wr_tag_i] <= wr_entry_i;
    end
  end

  // different tags on read and write never collide,
  // a live tag is only read after its write edge
  assign rd_entry_o = entries_r[rd_tag_i];

endmodule

// ==== bsg_id_pool.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pool of transaction tags. offers the
// lowest free tag on valid/yumi, takes
// tags back on dealloc, same cycle bypass.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bsg_id_pool (
  input  logic                             clk_i,
  input  logic                             reset_i,
  // next free tag
  output logic [tag_pkg::tag_width_lp-1:0] alloc_id_o,
  output logic                             alloc_v_o,
  input  logic                             alloc_yumi_i,
  // returned tag
  input  logic                             dealloc_v_i,
  input  logic [tag_pkg::tag_width_lp-1:0] dealloc_id_i
);

  import tag_pkg::*;

  logic [num_tags_lp-1:0] allocated_r;
  logic [num_tags_lp-1:0] dealloc_decode;
  logic [num_tags_lp-1:0] avail;
  logic [num_tags_lp-1:0] grant_onehot;
  logic [num_tags_lp-1:0] alloc_set;

  // one-hot of the tag being freed
  always_comb begin
    dealloc_decode = '0;
    if (dealloc_v_i) begin
      dealloc_decode[dealloc_id_i] = 1'b1;
    end
  end

  // a tag freed this cycle can be handed out right away
  assign avail = ~allocated_r | dealloc_decode;

  // lowest index wins
  always_comb begin
    logic found;
    found        = 1'b0;
    grant_onehot = '0;
    alloc_id_o   = '0;
    for (int i = 0; i < num_tags_lp; i++) begin
      if (avail[i] && !found) begin
        found           = 1'b1;
        grant_onehot[i] = 1'b1;
        alloc_id_o      = tag_width_lp'(i);
      end
    end
  end

  assign alloc_v_o = |avail;
  assign alloc_set = grant_onehot & {num_tags_lp{alloc_yumi_i}};

  // set after clear, so a same-cycle set wins
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      allocated_r <= '0;
    end else begin
      allocated_r <= (allocated_r & ~dealloc_decode) | alloc_set;
    end
  end

endmodule

// ==== tag_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared sizes, opcode enum and handshake
// payload structs for the tag tracker.
// modules take it by wildcard import.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package tag_pkg;

  // transaction tag space
  localparam int num_tags_lp   = 8;
  localparam int tag_width_lp  = 3;

  // payload sizes
  localparam int src_width_lp  = 4;
  localparam int addr_width_lp = 16;
  localparam int data_width_lp = 32;

  typedef enum logic [0:0] {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // request from an upstream requester
  typedef struct packed {
    logic [src_width_lp-1:0]  src;
    mem_op_e                  op;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] wdata;
  } up_req_s;

  // tagged request toward memory
  typedef struct packed {
    logic [tag_width_lp-1:0]  tag;
    mem_op_e                  op;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] wdata;
  } down_req_s;

  // memory response, rdata ignored for writes
  typedef struct packed {
    logic [tag_width_lp-1:0]  tag;
    logic [data_width_lp-1:0] rdata;
  } down_resp_s;

  typedef struct packed {
    logic [src_width_lp-1:0]  src;
    mem_op_e                  op;
    logic [data_width_lp-1:0] rdata;
  } up_resp_s;

  // what is remembered per outstanding tag
  typedef struct packed {
    logic [src_width_lp-1:0]  src;
    mem_op_e                  op;
    logic [addr_width_lp-1:0] addr;
  } tag_entry_s;

endpackage
